// ==== include/mul_params.svh ====
/*
 * width macros for the integer execute path
 * datapath, destination register address and multiplier step counter
 */
`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

// integer datapath width
`define MUL_XLEN 32

// destination register address width
`define MUL_REG_AW 5

// multiplier step counter, holds XLEN-1
`define MUL_CNT_W 5

`endif

// ==== src/mul_op_pkg.sv ====
/*
 * operation encodings for the execute path
 * execute op enum, multiplier half select and operand signedness
 */
package mul_op_pkg;

  localparam int unsigned EX_OP_W = 3;

  // msb set marks the multiplier class
  typedef enum logic [EX_OP_W-1:0] {
    EX_ADD    = 3'b000,
    EX_SUB    = 3'b001,
    EX_SLT    = 3'b010,
    EX_SLTU   = 3'b011,
    EX_MUL    = 3'b100,
    EX_MULH   = 3'b101,
    EX_MULHSU = 3'b110,
    EX_MULHU  = 3'b111
  } ex_op_e;

  // which half of the product is returned
  typedef enum logic {
    MUL_L = 1'b0,
    MUL_H = 1'b1
  } mult_operator_e;

  // bit 0 operand a signed, bit 1 operand b signed
  typedef logic [1:0] signed_mode_t;

  localparam signed_mode_t SMODE_UU = 2'b00;
  localparam signed_mode_t SMODE_SU = 2'b01;
  localparam signed_mode_t SMODE_SS = 2'b11;

  function automatic logic is_mult_op(input ex_op_e op);
    return op[EX_OP_W-1];
  endfunction

endpackage

// ==== src/mul_data_pkg.sv ====
/*
 * structs passed between the pipeline stages
 * issue word, alu and multiplier control, writeback result
 */
`include "mul_params.svh"

package mul_data_pkg;
  import mul_op_pkg::*;

  ////////////////////
  // issue side
  ////////////////////

  // one instruction as presented by the environment
  typedef struct packed {
    ex_op_e                 op;
    logic [`MUL_XLEN-1:0]   op_a;
    logic [`MUL_XLEN-1:0]   op_b;
    logic [`MUL_REG_AW-1:0] rd;
  } issue_t;

  ////////////////////
  // execute control
  ////////////////////

  // alu control, valid travels as a separate wire
  typedef struct packed {
    ex_op_e                 op;
    logic [`MUL_XLEN-1:0]   op_a;
    logic [`MUL_XLEN-1:0]   op_b;
    logic [`MUL_REG_AW-1:0] rd;
  } alu_ctrl_t;

  // multiplier control, held stable for the whole run
  typedef struct packed {
    mult_operator_e         operator;
    signed_mode_t           signed_mode;
    logic [`MUL_XLEN-1:0]   op_a;
    logic [`MUL_XLEN-1:0]   op_b;
    logic [`MUL_REG_AW-1:0] rd;
  } mult_ctrl_t;

  // result with its destination
  typedef struct packed {
    logic [`MUL_REG_AW-1:0] rd;
    logic [`MUL_XLEN-1:0]   result;
  } wb_t;

endpackage

// ==== src/mul_decode.sv ====
/*
 * issue and decode stage
 * registers accepted ops, routes them to alu or multiplier, owns busy
 */
`timescale 1ns/1ns
`include "mul_params.svh"

module mul_decode
  import mul_op_pkg::*;
  import mul_data_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       issue_valid_i,
  input  issue_t     issue_i,
  input  logic       mult_done_i,
  output logic       alu_valid_o,
  output alu_ctrl_t  alu_ctrl_o,
  output logic       mult_en_o,
  output mult_ctrl_t mult_ctrl_o,
  output logic       busy_o
);

  logic       accept;
  logic       alu_issue;
  logic       mult_issue;
  logic       alu_valid_q;
  logic       mult_start_q;
  logic       mult_en_q;
  logic       busy_q;
  alu_ctrl_t  alu_ctrl_q;
  mult_ctrl_t mult_ctrl_q;
  mult_ctrl_t mult_dec;

  // busy drops as soon as the ready pulse is seen
  assign busy_o     = busy_q & ~mult_done_i;
  // issues while busy are dropped
  assign accept     = issue_valid_i & ~busy_o;
  assign mult_issue = accept & is_mult_op(issue_i.op);
  assign alu_issue  = accept & ~is_mult_op(issue_i.op);

  // expand a multiply op into half select and signedness
  always_comb begin
    mult_dec.op_a        = issue_i.op_a;
    mult_dec.op_b        = issue_i.op_b;
    mult_dec.rd          = issue_i.rd;
    mult_dec.operator    = MUL_H;
    mult_dec.signed_mode = SMODE_UU;
    case (issue_i.op)
      EX_MUL:    mult_dec.operator    = MUL_L;
      EX_MULH:   mult_dec.signed_mode = SMODE_SS;
      EX_MULHSU: mult_dec.signed_mode = SMODE_SU;
      default:   mult_dec.signed_mode = SMODE_UU;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alu_valid_q  <= 1'b0;
      mult_start_q <= 1'b0;
      mult_en_q    <= 1'b0;
      busy_q       <= 1'b0;
    end else begin
      alu_valid_q  <= alu_issue;
      mult_start_q <= mult_issue;
      if (mult_issue) begin
        busy_q <= 1'b1;
      end else if (mult_done_i) begin
        busy_q <= 1'b0;
      end
      // enable runs from the cycle after start up to the ready pulse
      if (mult_start_q) begin
        mult_en_q <= 1'b1;
      end else if (mult_done_i) begin
        mult_en_q <= 1'b0;
      end
    end
  end

  // operand payload, loaded only on an accepted issue
  always_ff @(posedge clk) begin
    if (alu_issue) begin
      alu_ctrl_q <= '{op: issue_i.op, op_a: issue_i.op_a, op_b: issue_i.op_b, rd: issue_i.rd};
    end
    if (mult_issue) begin
      mult_ctrl_q <= mult_dec;
    end
  end

  assign alu_valid_o = alu_valid_q;
  assign alu_ctrl_o  = alu_ctrl_q;
  assign mult_en_o   = mult_en_q;
  assign mult_ctrl_o = mult_ctrl_q;

endmodule

// ==== src/mul_alu.sv ====
/*
 * combinational alu for add, sub and compares
 * one 33-bit adder, lent to the multiplier while it is enabled
 */
`timescale 1ns/1ns
`include "mul_params.svh"

module mul_alu
  import mul_op_pkg::*;
  import mul_data_pkg::*;
(
  input  logic                 alu_valid_i,
  input  alu_ctrl_t            alu_ctrl_i,
  input  logic                 mult_en_i,
  input  logic [`MUL_XLEN:0]   mult_operand_a_i,
  input  logic [`MUL_XLEN:0]   mult_operand_b_i,
  output logic [`MUL_XLEN+1:0] adder_ext_o,
  output logic                 alu_valid_o,
  output wb_t                  alu_res_o
);

  logic                 negate;
  logic [`MUL_XLEN:0]   operand_b_neg;
  logic [`MUL_XLEN:0]   adder_in_a;
  logic [`MUL_XLEN:0]   adder_in_b;
  logic [`MUL_XLEN-1:0] adder_res;
  logic                 sign_a;
  logic                 sign_b;
  logic                 is_lt;
  logic [`MUL_XLEN-1:0] alu_res;

  ////////////////////
  // shared adder
  ////////////////////

  // everything but add subtracts
  assign negate = (alu_ctrl_i.op != EX_ADD);

  // the extra lsb carries the +1 of the two's complement
  assign operand_b_neg = {alu_ctrl_i.op_b, 1'b0} ^ {(`MUL_XLEN+1){negate}};

  // multiplier owns the adder inputs while it runs
  assign adder_in_a = mult_en_i ? mult_operand_a_i : {alu_ctrl_i.op_a, 1'b1};
  assign adder_in_b = mult_en_i ? mult_operand_b_i : operand_b_neg;

  // 34-bit sum keeps the carry for the high-half window shift
  assign adder_ext_o = {1'b0, adder_in_a} + {1'b0, adder_in_b};
  assign adder_res   = adder_ext_o[`MUL_XLEN:1];

  ////////////////////
  // compares
  ////////////////////

  assign sign_a = alu_ctrl_i.op_a[`MUL_XLEN-1];
  assign sign_b = alu_ctrl_i.op_b[`MUL_XLEN-1];

  // equal msbs cannot overflow, so the difference sign decides
  // unequal msbs decide alone: a negative for slt, b large for sltu
  always_comb begin
    if (sign_a == sign_b) begin
      is_lt = adder_res[`MUL_XLEN-1];
    end else if (alu_ctrl_i.op == EX_SLT) begin
      is_lt = sign_a;
    end else begin
      is_lt = sign_b;
    end
  end

  always_comb begin
    case (alu_ctrl_i.op)
      EX_SLT, EX_SLTU: alu_res = {{(`MUL_XLEN-1){1'b0}}, is_lt};
      default:         alu_res = adder_res;
    endcase
  end

  // adder results are meaningless while lent out
  assign alu_valid_o      = alu_valid_i & ~mult_en_i;
  assign alu_res_o.rd     = alu_ctrl_i.rd;
  assign alu_res_o.result = alu_res;

endmodule

// ==== src/mul_serial.sv ====
/*
 * iterative shift-and-add multiplier
 * one partial product per cycle through the alu adder
 * low or high half, signed, unsigned or mixed operands
 */
`timescale 1ns/1ns
`include "mul_params.svh"

module mul_serial
  import mul_op_pkg::*;
  import mul_data_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 mult_en_i,
  input  mult_ctrl_t           mult_ctrl_i,
  input  logic [`MUL_XLEN+1:0] adder_ext_i,
  output logic [`MUL_XLEN:0]   alu_operand_a_o,
  output logic [`MUL_XLEN:0]   alu_operand_b_o,
  output logic                 mult_valid_o,
  output wb_t                  mult_res_o
);

  typedef enum logic [1:0] {
    MULT_IDLE,
    MULT_COMP,
    MULT_LASTPP,
    MULT_FINISH
  } mult_state_e;

  mult_state_e           state_q;
  logic [`MUL_CNT_W-1:0] step_cnt_q;

  logic [`MUL_XLEN:0]    accum_q;
  logic [`MUL_XLEN:0]    op_a_shift_q;
  logic [`MUL_XLEN:0]    op_b_shift_q;
  logic [`MUL_XLEN:0]    op_a_ext;
  logic [`MUL_XLEN:0]    op_b_ext;
  logic [`MUL_XLEN:0]    pp;
  logic [`MUL_XLEN:0]    last_pp;
  logic [`MUL_XLEN:0]    res_adder_l;
  logic [`MUL_XLEN:0]    res_adder_h;
  logic [`MUL_XLEN-1:0]  b_bit;
  logic                  b0_init;
  logic                  is_high;

  assign is_high = (mult_ctrl_i.operator == MUL_H);

  // sign extension only for operands marked signed
  assign op_a_ext = {mult_ctrl_i.op_a[`MUL_XLEN-1] & mult_ctrl_i.signed_mode[0], mult_ctrl_i.op_a};
  assign op_b_ext = {mult_ctrl_i.op_b[`MUL_XLEN-1] & mult_ctrl_i.signed_mode[1], mult_ctrl_i.op_b};
  assign b0_init  = mult_ctrl_i.op_b[0];

  // plain sum for the low half
  assign res_adder_l = adder_ext_i[`MUL_XLEN:0];
  // sum shifted one right, the window slides up the product
  assign res_adder_h = adder_ext_i[`MUL_XLEN+1:1];

  ////////////////////
  // partial products
  ////////////////////

  assign b_bit = {`MUL_XLEN{op_b_shift_q[0]}};

  // sign term inverted for the two's complement correction
  assign pp      = {~(op_a_shift_q[`MUL_XLEN] & op_b_shift_q[0]),
                    op_a_shift_q[`MUL_XLEN-1:0] & b_bit};
  // last row carries the sign of b, so its magnitude bits invert
  assign last_pp = {op_a_shift_q[`MUL_XLEN] & op_b_shift_q[0],
                    ~(op_a_shift_q[`MUL_XLEN-1:0] & b_bit)};

  always_comb begin
    alu_operand_a_o = accum_q;
    alu_operand_b_o = pp;
    if (is_high && (state_q == MULT_LASTPP)) begin
      alu_operand_b_o = last_pp;
    end
  end

  ////////////////////
  // control FSM
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= MULT_IDLE;
      step_cnt_q <= '0;
    end else if (mult_en_i) begin
      case (state_q)
        MULT_IDLE: begin
          step_cnt_q <= `MUL_CNT_W'(`MUL_XLEN - 1);
          state_q    <= MULT_COMP;
        end
        MULT_COMP: begin
          step_cnt_q <= step_cnt_q - 1'b1;
          if (step_cnt_q == `MUL_CNT_W'(1)) begin
            state_q <= MULT_LASTPP;
          end
        end
        MULT_LASTPP: state_q <= MULT_FINISH;
        default:     state_q <= MULT_IDLE;
      endcase
    end
  end

  // datapath registers follow the FSM
  always_ff @(posedge clk) begin
    if (mult_en_i) begin
      case (state_q)
        MULT_IDLE: begin
          op_a_shift_q <= is_high ? op_a_ext : op_a_ext << 1;
          op_b_shift_q <= op_b_ext >> 1;
          // first row is loaded straight, no adder pass
          if (is_high) begin
            accum_q <= {1'b1, ~(op_a_ext[`MUL_XLEN] & b0_init),
                        op_a_ext[`MUL_XLEN-1:1] & {(`MUL_XLEN-1){b0_init}}};
          end else begin
            accum_q <= {~(op_a_ext[`MUL_XLEN] & b0_init),
                        op_a_ext[`MUL_XLEN-1:0] & {`MUL_XLEN{b0_init}}};
          end
        end
        MULT_COMP: begin
          if (!is_high) begin
            op_a_shift_q <= op_a_shift_q << 1;
          end
          op_b_shift_q <= op_b_shift_q >> 1;
          accum_q      <= is_high ? res_adder_h : res_adder_l;
        end
        MULT_LASTPP: accum_q <= res_adder_l;
        default: ;
      endcase
    end
  end

  assign mult_valid_o      = (state_q == MULT_FINISH);
  assign mult_res_o.rd     = mult_ctrl_i.rd;
  assign mult_res_o.result = accum_q[`MUL_XLEN-1:0];

endmodule

// ==== src/mul_writeback.sv ====
/*
 * writeback stage
 * picks the alu or multiplier result and registers it for one cycle
 */
`timescale 1ns/1ns
`include "mul_params.svh"

module mul_writeback
  import mul_data_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic alu_valid_i,
  input  wb_t  alu_res_i,
  input  logic mult_valid_i,
  input  wb_t  mult_res_i,
  output logic wb_valid_o,
  output wb_t  wb_o
);

  logic any_valid;
  wb_t  wb_sel;
  logic wb_valid_q;
  wb_t  wb_q;

  ////////////////////
  // source select
  ////////////////////

  // both sources are never valid together
  assign any_valid = alu_valid_i | mult_valid_i;

  always_comb begin
    if (mult_valid_i) begin
      wb_sel = mult_res_i;
    end else begin
      wb_sel = alu_res_i;
    end
  end

  ////////////////////
  // output register
  ////////////////////

  // valid is a single-cycle pulse per result
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= any_valid;
    end
  end

  // result and destination hold until the next one
  always_ff @(posedge clk) begin
    if (any_valid) begin
      wb_q <= wb_sel;
    end
  end

  assign wb_valid_o = wb_valid_q;
  assign wb_o       = wb_q;

endmodule

// ==== src/mul_ex_top.sv ====
/*
 * integer execute path top level
 * decode, alu, serial multiplier and writeback
 */
`timescale 1ns/1ns
`include "mul_params.svh"

module mul_ex_top
  import mul_data_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   issue_valid_i,
  input  issue_t issue_i,
  output logic   busy_o,
  output logic   wb_valid_o,
  output wb_t    wb_o
);

  // decode to execute
  logic                 alu_valid;
  alu_ctrl_t            alu_ctrl;
  logic                 mult_en;
  mult_ctrl_t           mult_ctrl;

  // adder lent from alu to multiplier
  logic [`MUL_XLEN:0]   mult_operand_a;
  logic [`MUL_XLEN:0]   mult_operand_b;
  logic [`MUL_XLEN+1:0] adder_ext;

  // execute to writeback
  logic                 alu_done_valid;
  wb_t                  alu_done;
  logic                 mult_done_valid;
  wb_t                  mult_done;

  mul_decode u_decode (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue_valid_i (issue_valid_i),
    .issue_i       (issue_i),
    .mult_done_i   (mult_done_valid),
    .alu_valid_o   (alu_valid),
    .alu_ctrl_o    (alu_ctrl),
    .mult_en_o     (mult_en),
    .mult_ctrl_o   (mult_ctrl),
    .busy_o        (busy_o)
  );

  mul_alu u_alu (
    .alu_valid_i      (alu_valid),
    .alu_ctrl_i       (alu_ctrl),
    .mult_en_i        (mult_en),
    .mult_operand_a_i (mult_operand_a),
    .mult_operand_b_i (mult_operand_b),
    .adder_ext_o      (adder_ext),
    .alu_valid_o      (alu_done_valid),
    .alu_res_o        (alu_done)
  );

  mul_serial u_serial (
    .clk             (clk),
    .rst_n           (rst_n),
    .mult_en_i       (mult_en),
    .mult_ctrl_i     (mult_ctrl),
    .adder_ext_i     (adder_ext),
    .alu_operand_a_o (mult_operand_a),
    .alu_operand_b_o (mult_operand_b),
    .mult_valid_o    (mult_done_valid),
    .mult_res_o      (mult_done)
  );

  mul_writeback u_writeback (
    .clk          (clk),
    .rst_n        (rst_n),
    .alu_valid_i  (alu_done_valid),
    .alu_res_i    (alu_done),
    .mult_valid_i (mult_done_valid),
    .mult_res_i   (mult_done),
    .wb_valid_o   (wb_valid_o),
    .wb_o         (wb_o)
  );

endmodule

// ==== sim/mul_ex_props.sv ====
/*
 * assertions on the execute path ports
 * result pulses, busy after reset and alu latency
 */
`timescale 1ns/1ns

module mul_ex_props
  import mul_op_pkg::*;
  import mul_data_pkg::*;
(
  input logic   clk,
  input logic   rst_n,
  input logic   issue_valid_i,
  input issue_t issue_i,
  input logic   busy_i,
  input logic   wb_valid_i,
  input wb_t    wb_i
);

  logic       accept;
  logic       alu_accept;
  logic [7:0] pending_q;

  // an issue counts only while the path is not busy
  assign accept     = issue_valid_i & ~busy_i;
  assign alu_accept = accept & (issue_i.op inside {EX_ADD, EX_SUB, EX_SLT, EX_SLTU});

  // ops accepted but not yet written back
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_q + {7'd0, accept} - {7'd0, wb_valid_i};
    end
  end

  ////////////////////
  // result pulses
  ////////////////////

  result_has_issue: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid_i |-> (pending_q != 8'd0))
    else $error("result pulse with no pending issue");

  // valid stays high a second cycle only for back to back alu ops
  single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_valid_i && $past(wb_valid_i)) |-> $past(alu_accept, 2))
    else $error("result valid held longer than one cycle");

  ////////////////////
  // reset and latency
  ////////////////////

  idle_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> (!busy_i && !wb_valid_i))
    else $error("busy or result valid high after reset");

  alu_two_cycles: assert property (@(posedge clk) disable iff (!rst_n)
    $past(alu_accept, 2) |-> (wb_valid_i && (wb_i.rd == $past(issue_i.rd, 2))))
    else $error("alu result not written back two cycles after issue");

endmodule

// ==== sim/tb_mul_ex.sv ====
/*
 * testbench for the integer execute path
 * seeded random alu and multiply ops, reference model, scoreboard
 */
`timescale 1ns/1ns
`include "mul_params.svh"

module tb_mul_ex
  import mul_op_pkg::*;
  import mul_data_pkg::*;
();

  localparam int XL       = `MUL_XLEN;
  localparam int ALU_LAT  = 2;
  localparam int MULT_LAT = 36;
  // busy drops in the cycle before the multiply result
  localparam int BUSY_END = MULT_LAT - 1;

  logic   clk;
  logic   rst_n;
  logic   issue_valid;
  issue_t issue;
  logic   busy;
  logic   wb_valid;
  wb_t    wb;

  integer seed;
  int     cyc;
  int     mult_issue_cyc;
  int     err_cnt;
  int     check_cnt;
  // expected results in issue order, with the cycle each is due
  wb_t    exp_q[$];
  int     due_q[$];

  mul_ex_top dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue_valid_i (issue_valid),
    .issue_i       (issue),
    .busy_o        (busy),
    .wb_valid_o    (wb_valid),
    .wb_o          (wb)
  );

  bind mul_ex_top mul_ex_props u_props (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue_valid_i (issue_valid_i),
    .issue_i       (issue_i),
    .busy_i        (busy_o),
    .wb_valid_i    (wb_valid_o),
    .wb_i          (wb_o)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_wb(input string name, input wb_t got, input wb_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED t=%0t %s got rd=%0d result=%h expected rd=%0d result=%h",
               $time, name, got.rd, got.result, exp.rd, exp.result);
    end
  endtask

  ////////////////////
  // reference model
  ////////////////////

  function automatic wb_t model_result(input issue_t iss);
    logic [2*XL-1:0] a_zx;
    logic [2*XL-1:0] a_sx;
    logic [2*XL-1:0] b_zx;
    logic [2*XL-1:0] b_sx;
    logic [2*XL-1:0] prod;
    wb_t             res;
    a_zx = {{XL{1'b0}}, iss.op_a};
    a_sx = {{XL{iss.op_a[XL-1]}}, iss.op_a};
    b_zx = {{XL{1'b0}}, iss.op_b};
    b_sx = {{XL{iss.op_b[XL-1]}}, iss.op_b};
    // full width product, mod 2^64 keeps signed results exact
    case (iss.op)
      EX_MULH:   prod = a_sx * b_sx;
      EX_MULHSU: prod = a_sx * b_zx;
      default:   prod = a_zx * b_zx;
    endcase
    res.rd = iss.rd;
    case (iss.op)
      EX_ADD:  res.result = iss.op_a + iss.op_b;
      EX_SUB:  res.result = iss.op_a - iss.op_b;
      EX_SLT:  res.result = ($signed(iss.op_a) < $signed(iss.op_b)) ? XL'(1) : XL'(0);
      EX_SLTU: res.result = (iss.op_a < iss.op_b) ? XL'(1) : XL'(0);
      EX_MUL:  res.result = prod[XL-1:0];
      default: res.result = prod[2*XL-1:XL];
    endcase
    return res;
  endfunction

  ////////////////////
  // cycle and stimulus
  ////////////////////

  // sample outputs at the falling edge, then release the issue strobe
  task automatic next_cycle();
    logic exp_valid;
    @(negedge clk);
    cyc++;
    issue_valid = 1'b0;
    exp_valid = (due_q.size() > 0) && (due_q[0] == cyc);
    check_flag("busy_o", busy, (cyc > mult_issue_cyc) && (cyc < mult_issue_cyc + BUSY_END));
    check_flag("wb_valid_o", wb_valid, exp_valid);
    if (exp_valid) begin
      if (wb_valid) begin
        check_wb("wb_o", wb, exp_q[0]);
      end
      void'(exp_q.pop_front());
      void'(due_q.pop_front());
    end
  endtask

  task automatic issue_op(input ex_op_e op, input logic [XL-1:0] a, input logic [XL-1:0] b);
    issue_t      iss;
    logic [31:0] r;
    r        = $random(seed);
    iss.op   = op;
    iss.op_a = a;
    iss.op_b = b;
    iss.rd   = r[`MUL_REG_AW-1:0];
    issue       = iss;
    issue_valid = 1'b1;
    exp_q.push_back(model_result(iss));
    if (op inside {EX_MUL, EX_MULH, EX_MULHSU, EX_MULHU}) begin
      due_q.push_back(cyc + MULT_LAT);
      mult_issue_cyc = cyc;
    end else begin
      due_q.push_back(cyc + ALU_LAT);
    end
  endtask

  // half of the operands come from the corner set
  task automatic pick_operand(output logic [XL-1:0] v);
    logic [31:0] r;
    logic [31:0] w;
    r = $random(seed);
    w = $random(seed);
    case (r[2:0])
      3'd0:    v = '0;
      3'd1:    v = XL'(1);
      3'd2:    v = '1;
      3'd3:    v = {1'b1, {(XL-1){1'b0}}};
      default: v = w[XL-1:0];
    endcase
  endtask

  task automatic drain_results(input int limit);
    int n;
    n = 0;
    while ((exp_q.size() > 0) && (n < limit)) begin
      next_cycle();
      n++;
    end
    if (exp_q.size() > 0) begin
      err_cnt++;
      $display("timeout: %0d results still missing after %0d cycles", exp_q.size(), limit);
      exp_q.delete();
      due_q.delete();
    end
  endtask

  // every corner pair, then random operands
  task automatic run_mult(input ex_op_e op, input int n_rand);
    logic [XL-1:0] corner [4];
    logic [XL-1:0] a;
    logic [XL-1:0] b;
    corner[0] = '0;
    corner[1] = XL'(1);
    corner[2] = '1;
    corner[3] = {1'b1, {(XL-1){1'b0}}};
    for (int i = 0; i < 16 + n_rand; i++) begin
      if (i < 16) begin
        a = corner[i[3:2]];
        b = corner[i[1:0]];
      end else begin
        pick_operand(a);
        pick_operand(b);
      end
      next_cycle();
      issue_op(op, a, b);
      drain_results(MULT_LAT + 4);
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    if (err_cnt == err_start) begin
      $display("test %-12s ok", name);
    end else begin
      $display("test %-12s %0d errors", name, err_cnt - err_start);
    end
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    int            e0;
    int            n;
    int            issued;
    logic [31:0]   r;
    logic [XL-1:0] a;
    logic [XL-1:0] b;
    seed           = 32'h56c6_afb4;
    rst_n          = 1'b0;
    issue_valid    = 1'b0;
    issue          = '0;
    cyc            = 0;
    mult_issue_cyc = -100;
    err_cnt        = 0;
    check_cnt      = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // quiet after reset
    e0 = err_cnt;
    repeat (20) next_cycle();
    finish_test("reset", e0);

    // one alu op per cycle
    e0 = err_cnt;
    for (int i = 0; i < 200; i++) begin
      next_cycle();
      r = $random(seed);
      pick_operand(a);
      pick_operand(b);
      issue_op(ex_op_e'({1'b0, r[1:0]}), a, b);
    end
    drain_results(ALU_LAT + 4);
    finish_test("alu_stream", e0);

    e0 = err_cnt;
    run_mult(EX_MUL, 24);
    finish_test("mul_low", e0);

    e0 = err_cnt;
    run_mult(EX_MULH, 24);
    run_mult(EX_MULHSU, 24);
    run_mult(EX_MULHU, 24);
    finish_test("mul_high", e0);

    // alu op in the cycle busy drops, while the adder comes back
    e0 = err_cnt;
    for (int i = 0; i < 4; i++) begin
      pick_operand(a);
      pick_operand(b);
      next_cycle();
      issue_op(ex_op_e'({1'b1, i[1:0]}), a, b);
      n = 0;
      next_cycle();
      while (busy && (n < MULT_LAT + 4)) begin
        next_cycle();
        n++;
      end
      if (busy) begin
        err_cnt++;
        $display("timeout: busy_o never dropped after a multiply");
      end
      issue_op(ex_op_e'({1'b0, i[1:0]}), b, a);
      drain_results(MULT_LAT + 4);
    end
    finish_test("busy_window", e0);

    // random mix, issued whenever busy is low
    e0 = err_cnt;
    n = 0;
    issued = 0;
    while ((issued < 150) && (n < 20000)) begin
      next_cycle();
      n++;
      r = $random(seed);
      if (!busy && r[3]) begin
        pick_operand(a);
        pick_operand(b);
        issue_op(ex_op_e'(r[2:0]), a, b);
        issued++;
      end
    end
    if (issued < 150) begin
      err_cnt++;
      $display("timeout: mixed stream issued only %0d ops", issued);
    end
    drain_results(MULT_LAT + 4);
    finish_test("mixed", e0);

    $display("summary: %0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+include
src/mul_op_pkg.sv
src/mul_data_pkg.sv
src/mul_decode.sv
src/mul_alu.sv
src/mul_serial.sv
src/mul_writeback.sv
src/mul_ex_top.sv
sim/mul_ex_props.sv
sim/tb_mul_ex.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the execute path testbench with verilator
# the run passes only if the log holds the pass message

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_mul_ex

verilator --binary --timing --assert -Wno-fatal \
  -f src.f \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR"
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$LOG_FILE"; then
  exit 0
fi

echo "pass message not found in $LOG_FILE"
exit 1
